// ==== fp_cfg_pkg.sv ====
package fp_cfg_pkg;

    // arithmetic right shift of the summed channel term.
    localparam int chan_shift_factor = 3;

    // pattern table geometry.
    localparam int num_patterns  = 4;
    localparam int flip_depth    = 3;
    localparam int pat_idx_width = $clog2(num_patterns);

    // default data widths.
    localparam int def_err_width  = 8;
    localparam int def_chan_width = 8;
    localparam int def_ener_width = 18;

    // flip masks indexed by pattern number.
    localparam logic [num_patterns-1:0][flip_depth-1:0] pattern_table = {
        3'b111,   // triple flip
        3'b011,   // double flip
        3'b010,   // single flip at the centre
        3'b000    // baseline
    };

endpackage

// ==== fp_types_pkg.sv ====
package fp_types_pkg;

    // one decided bit with its estimation residual.
    typedef struct packed {
        logic signed [fp_cfg_pkg::def_err_width-1:0] residual;
        logic                                        bit_val;
    } fp_sample_t;

    // winning pattern of one window.
    typedef struct packed {
        logic [fp_cfg_pkg::pat_idx_width-1:0]  best_idx;
        logic [fp_cfg_pkg::def_ener_width-1:0] best_mse;
        logic [fp_cfg_pkg::flip_depth-1:0]     flip_mask;
        logic                                  overflow;
    } fp_result_t;

endpackage

// ==== fp_window.sv ====
module fp_window #(
    parameter int  seq_length = 3,
    parameter int  err_width  = 8,
    parameter int  chan_width = 8,
    localparam int win_len    = seq_length + fp_cfg_pkg::flip_depth - 1
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  fp_types_pkg::fp_sample_t           in_sample,
    input  logic                               chan_load,
    input  logic [win_len-1:0][chan_width-1:0] chan_taps,
    output logic [win_len-1:0][err_width-1:0]  res_win,
    output logic [win_len-1:0]                 bit_win,
    output logic [win_len-1:0][chan_width-1:0] taps,
    output logic                               win_valid
);

    localparam int cnt_w = $clog2(win_len + 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(win_len);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(win_len - 1);

    logic [cnt_w-1:0] fill_cnt;

    // newest sample sits at index 0.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            res_win <= {res_win[win_len-2:0], in_sample.residual};
            bit_win <= {bit_win[win_len-2:0], in_sample.bit_val};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            win_valid <= 1'b0;
            taps      <= '0;
        end else begin
            // the sample that completes the window already yields a result.
            win_valid <= in_valid && (fill_cnt >= last_cnt);
            if (in_valid && (fill_cnt != full_cnt)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (chan_load) begin
                taps <= chan_taps;
            end
        end
    end

endmodule

// ==== fp_checker.sv ====
module fp_checker #(
    parameter int                    seq_length   = 3,
    parameter int                    flip_depth   = fp_cfg_pkg::flip_depth,
    parameter int                    cp           = 2,
    parameter int                    err_width    = 8,
    parameter int                    chan_width   = 8,
    parameter int                    ener_width   = 18,
    parameter logic [flip_depth-1:0] flip_pattern = '0,
    localparam int                   win_len      = seq_length + flip_depth - 1
) (
    input  logic [win_len-1:0][err_width-1:0]  res_win,
    input  logic [win_len-1:0]                 bit_win,
    input  logic [win_len-1:0][chan_width-1:0] taps,
    output logic [ener_width-1:0]              mse_val,
    output logic                               overflow
);

    import fp_cfg_pkg::*;

    // twice a tap, negated, needs two extra bits.
    localparam int pe_w  = chan_width + 2;
    localparam int sum_w = pe_w + $clog2(flip_depth);
    localparam int add_w = ((sum_w > err_width) ? sum_w : err_width) + 1;
    localparam int sq_w  = 2 * add_w;
    localparam int tot_w = sq_w + $clog2(seq_length);

    logic signed [pe_w-1:0]  pe      [flip_depth][seq_length];
    logic signed [sum_w-1:0] err_sum [seq_length];
    logic signed [add_w-1:0] err_adj [seq_length];
    logic [sq_w-1:0]         sq      [seq_length];
    logic [tot_w-1:0]        total;

    // partial errors of the flipped bits.
    for (genvar gi = 0; gi < flip_depth; gi++) begin : g_bit
        for (genvar ii = 0; ii < seq_length; ii++) begin : g_pos
            if (flip_pattern[gi] && (cp - gi + ii > 0)) begin : g_flip
                logic signed [pe_w-1:0] twice;

                assign twice      = pe_w'($signed(taps[cp - gi + ii])) <<< 1;
                assign pe[gi][ii] = bit_win[gi] ? -twice : twice;
            end else begin : g_zero
                assign pe[gi][ii] = '0;
            end
        end
    end

    always_comb begin
        total = '0;
        for (int ii = 0; ii < seq_length; ii++) begin
            err_sum[ii] = '0;
            for (int gi = 0; gi < flip_depth; gi++) begin
                err_sum[ii] = err_sum[ii] + sum_w'(pe[gi][ii]);
            end
            err_adj[ii] = add_w'(err_sum[ii] >>> chan_shift_factor)
                        + add_w'($signed(res_win[ii]));
            sq[ii]      = sq_w'(err_adj[ii]) * sq_w'(err_adj[ii]);
            total       = total + tot_w'(sq[ii]);
        end
    end

    // clip to the energy width.
    assign overflow = |total[tot_w-1:ener_width];
    assign mse_val  = overflow ? '1 : total[ener_width-1:0];

endmodule

// ==== fp_select.sv ====
module fp_select #(
    parameter int ener_width = 18
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                win_valid,
    input  logic [fp_cfg_pkg::num_patterns-1:0][ener_width-1:0] mse_vals,
    input  logic [fp_cfg_pkg::num_patterns-1:0]                 ovf_flags,
    output logic                                                out_valid,
    output fp_types_pkg::fp_result_t                            result
);

    import fp_cfg_pkg::*;

    logic [pat_idx_width-1:0] min_idx;
    logic [ener_width-1:0]    min_val;

    // strict compare keeps the lower index on a tie.
    always_comb begin
        min_idx = '0;
        min_val = mse_vals[0];
        for (int pi = 1; pi < num_patterns; pi++) begin
            if (mse_vals[pi] < min_val) begin
                min_idx = pat_idx_width'(pi);
                min_val = mse_vals[pi];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            result.best_idx  <= min_idx;
            result.best_mse  <= min_val;
            result.flip_mask <= pattern_table[min_idx];
            result.overflow  <= |ovf_flags;
        end
    end

endmodule

// ==== fp_top.sv ====
module fp_top #(
    parameter int  seq_length = 3,
    parameter int  cp         = 2,
    parameter int  err_width  = fp_cfg_pkg::def_err_width,
    parameter int  chan_width = fp_cfg_pkg::def_chan_width,
    parameter int  ener_width = fp_cfg_pkg::def_ener_width,
    localparam int tap_count  = seq_length + fp_cfg_pkg::flip_depth - 1
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  fp_types_pkg::fp_sample_t             in_sample,
    input  logic                                 chan_load,
    input  logic [tap_count-1:0][chan_width-1:0] chan_taps,
    output logic                                 out_valid,
    output fp_types_pkg::fp_result_t             result
);

    import fp_cfg_pkg::*;

    logic [tap_count-1:0][err_width-1:0]     res_win;
    logic [tap_count-1:0]                    bit_win;
    logic [tap_count-1:0][chan_width-1:0]    taps;
    logic                                    win_valid;
    logic [num_patterns-1:0][ener_width-1:0] mse_vals;
    logic [num_patterns-1:0]                 ovf_flags;

    fp_window #(
        .seq_length (seq_length),
        .err_width  (err_width),
        .chan_width (chan_width)
    ) u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .chan_load (chan_load),
        .chan_taps (chan_taps),
        .res_win   (res_win),
        .bit_win   (bit_win),
        .taps      (taps),
        .win_valid (win_valid)
    );

    // one energy evaluator per table entry.
    for (genvar pi = 0; pi < num_patterns; pi++) begin : g_pat
        fp_checker #(
            .seq_length   (seq_length),
            .flip_depth   (flip_depth),
            .cp           (cp),
            .err_width    (err_width),
            .chan_width   (chan_width),
            .ener_width   (ener_width),
            .flip_pattern (pattern_table[pi])
        ) u_checker (
            .res_win  (res_win),
            .bit_win  (bit_win),
            .taps     (taps),
            .mse_val  (mse_vals[pi]),
            .overflow (ovf_flags[pi])
        );
    end

    fp_select #(
        .ener_width (ener_width)
    ) u_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .mse_vals  (mse_vals),
        .ovf_flags (ovf_flags),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// ==== fp_props.sv ====
module fp_props #(
    parameter int win_len = 5
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     out_valid,
    input fp_types_pkg::fp_result_t result
);

    import fp_cfg_pkg::*;

    // samples taken since reset, counting stops once the window is full.
    int accepted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accepted <= 0;
        end else if (in_valid && accepted < win_len) begin
            accepted <= accepted + 1;
        end
    end

    a_rst_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

    // the sample that fills the window and every later one yield a result.
    a_follow: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && accepted >= win_len - 1) |=> ##1 out_valid)
        else $error("out_valid missing one cycle after an accepted sample");

    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ($past(in_valid, 2) && ($past(accepted, 2) >= win_len - 1)))
        else $error("out_valid without an accepted sample in a full window");

    a_mask: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (result.flip_mask == pattern_table[result.best_idx]))
        else $error("flip_mask does not match the pattern table");

    a_mse_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (!$isunknown(result.best_mse)
                       && (result.best_mse <= {def_ener_width{1'b1}})))
        else $error("best_mse unknown or out of range");

endmodule

bind fp_top fp_props #(
    .win_len (tap_count)
) u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

// ==== tb_fp_top.sv ====
module tb_fp_top;

    import fp_cfg_pkg::*;
    import fp_types_pkg::*;

    localparam int seq_length     = 3;
    localparam int cp             = 2;
    localparam int err_width      = def_err_width;
    localparam int chan_width     = def_chan_width;
    localparam int ener_width     = def_ener_width;
    localparam int win_len        = seq_length + flip_depth - 1;
    localparam int timeout_cycles = 40;

    typedef logic [win_len-1:0][chan_width-1:0] taps_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    fp_sample_t in_sample;
    logic       chan_load;
    taps_t      chan_taps;
    logic       out_valid;
    fp_result_t result;

    // mirror of the DUT window, newest sample at index 0.
    logic signed [err_width-1:0]  m_res  [win_len];
    logic                         m_bit  [win_len];
    logic signed [chan_width-1:0] m_taps [win_len];
    int                           m_fill;

    fp_result_t exp_q [$];
    int         due_q [$];
    int         cyc;
    int         err_cnt;
    int         chk_cnt;
    int         res_cnt;

    fp_top #(
        .seq_length (seq_length),
        .cp         (cp),
        .err_width  (err_width),
        .chan_width (chan_width),
        .ener_width (ener_width)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .chan_load (chan_load),
        .chan_taps (chan_taps),
        .out_valid (out_valid),
        .result    (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // energies of all patterns over the mirrored window, then the minimum.
    function automatic fp_result_t expected_result();
        fp_result_t            r;
        int                    total;
        int                    part;
        int                    adj;
        logic                  ovf;
        logic [ener_width-1:0] mse;
        r   = '0;
        ovf = 1'b0;
        for (int p = 0; p < num_patterns; p++) begin
            total = 0;
            for (int ii = 0; ii < seq_length; ii++) begin
                part = 0;
                for (int gi = 0; gi < flip_depth; gi++) begin
                    if (pattern_table[p][gi] && (cp - gi + ii > 0)) begin
                        if (m_bit[gi]) begin
                            part = part - 2 * int'(m_taps[cp - gi + ii]);
                        end else begin
                            part = part + 2 * int'(m_taps[cp - gi + ii]);
                        end
                    end
                end
                adj   = (part >>> chan_shift_factor) + int'(m_res[ii]);
                total = total + adj * adj;
            end
            if (total >= (1 << ener_width)) begin
                ovf = 1'b1;
                mse = '1;
            end else begin
                mse = total[ener_width-1:0];
            end
            if (p == 0 || mse < r.best_mse) begin
                r.best_idx = pat_idx_width'(p);
                r.best_mse = mse;
            end
        end
        r.flip_mask = pattern_table[r.best_idx];
        r.overflow  = ovf;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        chk_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
        end
    endtask

    always @(negedge clk) begin : compare_results
        fp_result_t want;
        int         due;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("ERROR: t=%0t out_valid pulsed with no result pending", $time);
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                res_cnt++;
                if (due != cyc) begin
                    err_cnt++;
                    $display("ERROR: t=%0t result came in cycle %0d, due in cycle %0d",
                             $time, cyc, due);
                end
                check_value("best_idx", 32'(result.best_idx), 32'(want.best_idx));
                check_value("best_mse", 32'(result.best_mse), 32'(want.best_mse));
                check_value("flip_mask", 32'(result.flip_mask), 32'(want.flip_mask));
                check_value("overflow", 32'(result.overflow), 32'(want.overflow));
            end
        end else if (rst_n && due_q.size() != 0 && due_q[0] <= cyc) begin
            err_cnt++;
            $display("ERROR: t=%0t no out_valid in cycle %0d where a result was due",
                     $time, due_q[0]);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    // called on a falling edge, returns on the next one.
    task automatic drive_sample(input logic [err_width-1:0] res, input logic b);
        in_valid           = 1'b1;
        in_sample.residual = res;
        in_sample.bit_val  = b;
        for (int k = win_len - 1; k > 0; k--) begin
            m_res[k] = m_res[k-1];
            m_bit[k] = m_bit[k-1];
        end
        m_res[0] = res;
        m_bit[0] = b;
        if (m_fill < win_len) begin
            m_fill++;
        end
        if (m_fill == win_len) begin
            exp_q.push_back(expected_result());
            due_q.push_back(cyc + 2);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic load_taps(input taps_t t);
        chan_load = 1'b1;
        chan_taps = t;
        for (int k = 0; k < win_len; k++) begin
            m_taps[k] = t[k];
        end
        @(negedge clk);
        chan_load = 1'b0;
    endtask

    function automatic taps_t random_taps();
        taps_t t;
        for (int k = 0; k < win_len; k++) begin
            t[k] = chan_width'($urandom);
        end
        return t;
    endfunction

    task automatic drive_random(input int count, input int gap_pct);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            if ($urandom_range(99) < gap_pct) begin
                @(negedge clk);
            end
            rnd = $urandom;
            drive_sample(rnd[err_width-1:0], rnd[err_width]);
        end
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("ERROR: timed out with %0d results still pending", exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int start_errs);
        if (err_cnt == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - start_errs);
        end
    endtask

    initial begin
        taps_t       t;
        int          e0;
        int          r0;
        logic [31:0] rnd;
        void'($urandom(32'h97fb));
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_sample = '0;
        chan_load = 1'b0;
        chan_taps = '0;
        cyc       = 0;
        err_cnt   = 0;
        chk_cnt   = 0;
        res_cnt   = 0;
        m_fill    = 0;
        for (int k = 0; k < win_len; k++) begin
            m_res[k]  = '0;
            m_bit[k]  = 1'b0;
            m_taps[k] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        e0 = err_cnt;
        r0 = res_cnt;
        drive_random(win_len, 100);
        wait_results();
        check_value("result_count", 32'(res_cnt - r0), 32'd1);
        end_test("reset_fill", e0);

        e0 = err_cnt;
        load_taps('0);
        drive_random(8, 0);
        wait_results();
        end_test("zero_taps", e0);

        e0 = err_cnt;
        load_taps(random_taps());
        drive_random(60, 30);
        wait_results();
        end_test("random", e0);

        // centre flip cancels a residual of -4 on every position.
        e0 = err_cnt;
        t    = '0;
        t[1] = 8'd16;
        t[2] = 8'd16;
        t[3] = 8'd16;
        load_taps(t);
        drive_sample(8'h00, 1'b0);
        drive_sample(8'h00, 1'b0);
        drive_sample(8'hfc, 1'b0);
        drive_sample(8'hfc, 1'b0);
        drive_sample(8'hfc, 1'b1);
        wait_results();
        check_value("best_idx", 32'(result.best_idx), 32'd1);
        load_taps('0);
        drive_sample(8'h05, 1'b1);
        wait_results();
        check_value("best_idx", 32'(result.best_idx), 32'd0);
        end_test("cancel_and_tie", e0);

        e0 = err_cnt;
        rnd = $urandom;
        for (int k = 0; k < win_len; k++) begin
            t[k] = rnd[k] ? 8'h7f : 8'h80;
        end
        load_taps(t);
        for (int n = 0; n < 20; n++) begin
            rnd = $urandom;
            drive_sample(rnd[0] ? 8'h7f : 8'h80, rnd[1]);
        end
        wait_results();
        end_test("extreme", e0);

        e0 = err_cnt;
        load_taps(random_taps());
        drive_random(10, 0);
        load_taps(random_taps());
        drive_random(10, 0);
        wait_results();
        end_test("reload_taps", e0);

        $display("results: %0d, checks: %0d, errors: %0d", res_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
fp_cfg_pkg.sv
fp_types_pkg.sv
fp_window.sv
fp_checker.sv
fp_select.sv
fp_top.sv
fp_props.sv
tb_fp_top.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_top -f tb.f \
    -o sim_tb_fp_top \
    && ./obj_dir/sim_tb_fp_top | tee /dev/stderr | grep -q -F '*** PASSED ***' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation did not pass"; exit 1; }
